//--- logic/fd_record_pkg.sv
/*
  food delivery record layout
  one 64-bit memory word per id, delivery-man half over restaurant half
*/
package fd_record_pkg;

  localparam int ID_W   = 8;
  localparam int SLOT_W = 8;
  localparam int CTM_W  = 16;
  localparam int WORD_W = 64;

  typedef logic [SLOT_W-1:0] slot_t;

  // low 32 bits, limit in the top byte
  typedef struct packed {
    slot_t limit;
    slot_t food1;
    slot_t food2;
    slot_t food3;
  } res_info_t;

  // high 32 bits, zero entry means empty
  typedef struct packed {
    logic [CTM_W-1:0] ctm1;
    logic [CTM_W-1:0] ctm2;
  } d_man_info_t;

  typedef struct packed {
    d_man_info_t d_man;
    res_info_t   res;
  } record_t;

endpackage

//--- logic/fd_cmd_pkg.sv
/*
  food delivery command definitions
  actions, error codes and the payloads passed between pipeline stages
*/
package fd_cmd_pkg;

  localparam int SERV_W        = 4;
  localparam int PENDING_DEPTH = 4;
  localparam int PEND_PTR_W    = $clog2(PENDING_DEPTH);

  // one-hot action codes of the command bus
  typedef enum logic [3:0] {
    Deliver = 4'd2,
    Order   = 4'd4
  } action_t;

  // 0 is no food and 1..3 pick a slot
  typedef logic [1:0] food_id_t;

  typedef enum logic [3:0] {
    No_err       = 4'd0,
    No_customers = 4'd3,
    Res_busy     = 4'd4
  } err_t;

  typedef struct packed {
    action_t                        action;
    logic [fd_record_pkg::ID_W-1:0] id;
    food_id_t                       food_id;
    logic [SERV_W-1:0]              servings;
  } cmd_t;

  typedef struct packed {
    cmd_t                   cmd;
    fd_record_pkg::record_t rec;
  } fetched_t;

  typedef struct packed {
    logic [fd_record_pkg::ID_W-1:0]   id;
    err_t                             err;
    fd_record_pkg::record_t           new_rec;
    logic [fd_record_pkg::WORD_W-1:0] info;
  } resolved_t;

endpackage

//--- logic/fd_mem_if.sv
/*
  record memory request/response bundle
  at most one request in flight, one response pulse per request
*/
`timescale 1ns/1ps

interface fd_mem_if #(
  parameter int ADDR_W = 8,
  parameter int DATA_W = 64
);
  logic              req_valid;
  logic              req_ready;
  logic              write;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic              rsp_valid;
  logic [DATA_W-1:0] rdata;

  // requester toward the memory
  modport arbiter (output req_valid, write, addr, wdata, input req_ready, rsp_valid, rdata);
  // memory-facing end, also what the arbiter shows its clients
  modport memory (input req_valid, write, addr, wdata, output req_ready, rsp_valid, rdata);

  modport fetch_client (output req_valid, write, addr, wdata,
                        input req_ready, rsp_valid, rdata);
  // commit only writes, acknowledge is enough
  modport commit_client (output req_valid, write, addr, wdata, input req_ready, rsp_valid);
endinterface

//--- logic/fd_pipe_reg.sv
/*
  one-entry valid/ready register slice
  full throughput and refills in the cycle its item leaves
*/
`timescale 1ns/1ps

module fd_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     inf,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     valid_q;
  payload_t data_q;

  assign in_ready  = !valid_q || out_ready;
  assign out_valid = valid_q;
  assign out_data  = data_q;

  always_ff @(posedge clk or negedge inf) begin
    if (!inf) begin
      valid_q <= 1'b0;
    end
    else if (in_ready) begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

  // upstream keeps a stalled item in place
  a_in_hold: assert property (@(posedge clk) disable iff (!inf)
    (in_valid && !in_ready) |=> in_valid && $stable(in_data));

endmodule

//--- logic/fd_mem_arbiter.sv
/*
  memory port arbiter
  grants commit before fetch with one request outstanding
  routes each response back to its owner
*/
`timescale 1ns/1ps

module fd_mem_arbiter (
  input logic       clk,
  input logic       inf,
  fd_mem_if.memory  fetch_port,
  fd_mem_if.memory  commit_port,
  fd_mem_if.arbiter mem
);

  logic busy;
  logic owner_commit;
  logic lock;
  logic lock_commit;
  logic pick_commit;
  logic accept;

  // a stalled request keeps its grant until memory takes it
  assign pick_commit = lock ? lock_commit : commit_port.req_valid;

  assign mem.req_valid = !busy && (pick_commit ? commit_port.req_valid : fetch_port.req_valid);
  assign mem.write     = pick_commit ? commit_port.write : fetch_port.write;
  assign mem.addr      = pick_commit ? commit_port.addr  : fetch_port.addr;
  assign mem.wdata     = pick_commit ? commit_port.wdata : fetch_port.wdata;
  assign accept        = mem.req_valid && mem.req_ready;

  assign commit_port.req_ready = !busy && pick_commit && mem.req_ready;
  assign fetch_port.req_ready  = !busy && !pick_commit && mem.req_ready;

  // ----------------------------------------------------------------------
  // response routing
  assign commit_port.rsp_valid = mem.rsp_valid && owner_commit;
  assign fetch_port.rsp_valid  = mem.rsp_valid && !owner_commit;
  assign commit_port.rdata     = mem.rdata;
  assign fetch_port.rdata      = mem.rdata;

  always_ff @(posedge clk or negedge inf) begin
    if (!inf) begin
      busy         <= 1'b0;
      owner_commit <= 1'b0;
      lock         <= 1'b0;
      lock_commit  <= 1'b0;
    end
    else begin
      if (accept) begin
        busy         <= 1'b1;
        owner_commit <= pick_commit;
      end
      else if (mem.rsp_valid) begin
        busy <= 1'b0;
      end
      lock        <= mem.req_valid && !mem.req_ready;
      lock_commit <= pick_commit;
    end
  end

  // stalled request stays on the port unchanged
  a_hold_request: assert property (@(posedge clk) disable iff (!inf)
    (mem.req_valid && !mem.req_ready) |=> mem.req_valid && $stable(mem.write)
      && $stable(mem.addr) && $stable(mem.wdata));
  a_rsp_expected: assert property (@(posedge clk) disable iff (!inf)
    mem.rsp_valid |-> busy);

endmodule

//--- logic/fd_fetch_stage.sv
/*
  fetch stage
  takes commands, tracks in-flight ids and reads each record once
*/
`timescale 1ns/1ps

module fd_fetch_stage (
  input  logic                 clk,
  input  logic                 inf,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  input  fd_cmd_pkg::cmd_t     cmd,
  input  logic                 pend_release,
  fd_mem_if.fetch_client       mem,
  output logic                 out_valid,
  input  logic                 out_ready,
  output fd_cmd_pkg::fetched_t out_data
);

  typedef enum logic [1:0] {F_IDLE, F_REQ, F_WAIT, F_PUSH} fstate_t;

  fstate_t                                 state;
  fd_cmd_pkg::fetched_t                    item_q;
  logic                                    run_q;
  logic                                    hit;
  logic                                    full;
  logic                                    cmd_xfer;
  logic                                    push_ready;
  logic [fd_cmd_pkg::PENDING_DEPTH-1:0]    pend_valid;
  logic [fd_record_pkg::ID_W-1:0]          pend_id [fd_cmd_pkg::PENDING_DEPTH];
  logic [fd_cmd_pkg::PEND_PTR_W-1:0]       wr_ptr;
  logic [fd_cmd_pkg::PEND_PTR_W-1:0]       rd_ptr;

  // ----------------------------------------------------------------------
  // pending-id scoreboard, entries retire in order
  always_comb begin
    hit = 1'b0;
    for (int i = 0; i < fd_cmd_pkg::PENDING_DEPTH; i++) begin
      hit = hit || (pend_valid[i] && pend_id[i] == cmd.id);
    end
  end

  assign full      = pend_valid[wr_ptr];
  assign cmd_ready = run_q && state == F_IDLE && !full && !hit;
  assign cmd_xfer  = cmd_valid && cmd_ready;

  always_ff @(posedge clk or negedge inf) begin
    if (!inf) begin
      pend_valid <= '0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
    end
    else begin
      if (cmd_xfer) begin
        pend_valid[wr_ptr] <= 1'b1;
        wr_ptr             <= wr_ptr + 1'b1;
      end
      if (pend_release) begin
        pend_valid[rd_ptr] <= 1'b0;
        rd_ptr             <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_xfer) begin
      pend_id[wr_ptr] <= cmd.id;
      item_q.cmd      <= cmd;
    end
    if (mem.rsp_valid) begin
      item_q.rec <= mem.rdata;
    end
  end

  // ----------------------------------------------------------------------
  // read sequencer
  assign mem.req_valid = state == F_REQ;
  assign mem.write     = 1'b0;
  assign mem.addr      = item_q.cmd.id;
  assign mem.wdata     = '0;

  always_ff @(posedge clk or negedge inf) begin
    if (!inf) begin
      state <= F_IDLE;
      run_q <= 1'b0;
    end
    else begin
      // hold off commands for the first cycle out of reset
      run_q <= 1'b1;
      case (state)
        F_IDLE: begin
          if (cmd_xfer) begin
            state <= F_REQ;
          end
        end
        F_REQ: begin
          if (mem.req_ready) begin
            state <= F_WAIT;
          end
        end
        F_WAIT: begin
          if (mem.rsp_valid) begin
            state <= F_PUSH;
          end
        end
        default: begin
          if (push_ready) begin
            state <= F_IDLE;
          end
        end
      endcase
    end
  end

  fd_pipe_reg #(.payload_t(fd_cmd_pkg::fetched_t)) out_slice (
    .clk      (clk),
    .inf      (inf),
    .in_valid (state == F_PUSH),
    .in_ready (push_ready),
    .in_data  (item_q),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data)
  );

  a_release_pending: assert property (@(posedge clk) disable iff (!inf)
    pend_release |-> |pend_valid);

endmodule

//--- logic/fd_resolve_stage.sv
/*
  resolve stage
  checks the fetched record and builds the error code, new record and info word
*/
`timescale 1ns/1ps

module fd_resolve_stage (
  input  logic                  clk,
  input  logic                  inf,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  fd_cmd_pkg::fetched_t  in_data,
  output logic                  out_valid,
  input  logic                  out_ready,
  output fd_cmd_pkg::resolved_t out_data
);

  // wide enough for three slots plus a request
  typedef logic [fd_record_pkg::SLOT_W+1:0] sum_t;

  fd_cmd_pkg::resolved_t  res_d;
  fd_record_pkg::record_t rec_new;
  fd_record_pkg::slot_t   serv;
  sum_t                   total;

  assign serv = fd_record_pkg::slot_t'(in_data.cmd.servings);

  always_comb begin
    rec_new     = in_data.rec;
    total       = '0;
    res_d.id    = in_data.cmd.id;
    res_d.err   = fd_cmd_pkg::No_err;
    res_d.info  = '0;
    if (in_data.cmd.action == fd_cmd_pkg::Order) begin
      total = sum_t'(in_data.rec.res.food1) + sum_t'(in_data.rec.res.food2)
            + sum_t'(in_data.rec.res.food3) + sum_t'(serv);
      if (total > sum_t'(in_data.rec.res.limit)) begin
        res_d.err = fd_cmd_pkg::Res_busy;
      end
      else begin
        case (in_data.cmd.food_id)
          2'd1: rec_new.res.food1 = in_data.rec.res.food1 + serv;
          2'd2: rec_new.res.food2 = in_data.rec.res.food2 + serv;
          2'd3: rec_new.res.food3 = in_data.rec.res.food3 + serv;
          default: rec_new.res = in_data.rec.res;
        endcase
        res_d.info = {{(fd_record_pkg::WORD_W/2){1'b0}}, rec_new.res};
      end
    end
    else begin
      if (in_data.rec.d_man == '0) begin
        res_d.err = fd_cmd_pkg::No_customers;
      end
      else begin
        // first customer leaves, second moves up
        rec_new.d_man.ctm1 = in_data.rec.d_man.ctm2;
        rec_new.d_man.ctm2 = '0;
        res_d.info = {rec_new.d_man, {(fd_record_pkg::WORD_W/2){1'b0}}};
      end
    end
    res_d.new_rec = rec_new;
  end

  fd_pipe_reg #(.payload_t(fd_cmd_pkg::resolved_t)) out_slice (
    .clk      (clk),
    .inf      (inf),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (res_d),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data)
  );

endmodule

//--- logic/fd_commit_stage.sv
/*
  commit stage
  writes back successful records, then presents the result and frees the id
*/
`timescale 1ns/1ps

module fd_commit_stage (
  input  logic                                   clk,
  input  logic                                   inf,
  input  logic                                   in_valid,
  output logic                                   in_ready,
  input  fd_cmd_pkg::resolved_t                  in_data,
  fd_mem_if.commit_client                        mem,
  output logic                                   pend_release,
  output logic                                   out_valid,
  input  logic                                   out_ready,
  output fd_cmd_pkg::err_t                       out_err,
  output logic                                   out_complete,
  output logic [fd_record_pkg::WORD_W-1:0]       out_info
);

  typedef enum logic [1:0] {C_IDLE, C_WRITE, C_WAIT, C_OUT} cstate_t;

  cstate_t               state;
  fd_cmd_pkg::resolved_t item_q;

  assign in_ready = state == C_IDLE;

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      item_q <= in_data;
    end
  end

  // ----------------------------------------------------------------------
  // write-back of the whole record
  assign mem.req_valid = state == C_WRITE;
  assign mem.write     = 1'b1;
  assign mem.addr      = item_q.id;
  assign mem.wdata     = item_q.new_rec;

  always_ff @(posedge clk or negedge inf) begin
    if (!inf) begin
      state <= C_IDLE;
    end
    else begin
      case (state)
        C_IDLE: begin
          if (in_valid) begin
            // errors skip the write
            state <= (in_data.err == fd_cmd_pkg::No_err) ? C_WRITE : C_OUT;
          end
        end
        C_WRITE: begin
          if (mem.req_ready) begin
            state <= C_WAIT;
          end
        end
        C_WAIT: begin
          if (mem.rsp_valid) begin
            state <= C_OUT;
          end
        end
        default: begin
          if (out_ready) begin
            state <= C_IDLE;
          end
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // result port
  assign out_valid    = state == C_OUT;
  assign out_err      = item_q.err;
  assign out_complete = out_valid && item_q.err == fd_cmd_pkg::No_err;
  assign out_info     = item_q.info;
  assign pend_release = out_valid && out_ready;

endmodule

//--- logic/fd_platform.sv
/*
  food delivery platform controller
  fetch, resolve and commit pipeline sharing one record memory port
*/
`timescale 1ns/1ps

module fd_platform (
  input  logic                                 clk,
  input  logic                                 inf,
  input  logic                                 cmd_valid,
  output logic                                 cmd_ready,
  input  fd_cmd_pkg::action_t                  cmd_action,
  input  logic [fd_record_pkg::ID_W-1:0]       cmd_id,
  input  fd_cmd_pkg::food_id_t                 cmd_food_id,
  input  logic [fd_cmd_pkg::SERV_W-1:0]        cmd_servings,
  output logic                                 out_valid,
  input  logic                                 out_ready,
  output fd_cmd_pkg::err_t                     out_err,
  output logic                                 out_complete,
  output logic [fd_record_pkg::WORD_W-1:0]     out_info,
  output logic                                 mem_req_valid,
  input  logic                                 mem_req_ready,
  output logic                                 mem_write,
  output logic [fd_record_pkg::ID_W-1:0]       mem_addr,
  output logic [fd_record_pkg::WORD_W-1:0]     mem_wdata,
  input  logic                                 mem_rsp_valid,
  input  logic [fd_record_pkg::WORD_W-1:0]     mem_rdata
);

  fd_cmd_pkg::cmd_t      cmd;
  fd_cmd_pkg::fetched_t  fetch_data;
  fd_cmd_pkg::resolved_t resolve_data;
  logic                  fetch_valid;
  logic                  fetch_ready;
  logic                  resolve_valid;
  logic                  resolve_ready;
  logic                  pend_release;

  fd_mem_if #(.ADDR_W(fd_record_pkg::ID_W), .DATA_W(fd_record_pkg::WORD_W)) fetch_mem ();
  fd_mem_if #(.ADDR_W(fd_record_pkg::ID_W), .DATA_W(fd_record_pkg::WORD_W)) commit_mem ();
  fd_mem_if #(.ADDR_W(fd_record_pkg::ID_W), .DATA_W(fd_record_pkg::WORD_W)) mem_bus ();

  assign cmd.action   = cmd_action;
  assign cmd.id       = cmd_id;
  assign cmd.food_id  = cmd_food_id;
  assign cmd.servings = cmd_servings;

  // memory side onto plain ports
  assign mem_req_valid     = mem_bus.req_valid;
  assign mem_write         = mem_bus.write;
  assign mem_addr          = mem_bus.addr;
  assign mem_wdata         = mem_bus.wdata;
  assign mem_bus.req_ready = mem_req_ready;
  assign mem_bus.rsp_valid = mem_rsp_valid;
  assign mem_bus.rdata     = mem_rdata;

  fd_fetch_stage fetch0 (
    .clk(clk), .inf(inf),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
    .pend_release(pend_release), .mem(fetch_mem),
    .out_valid(fetch_valid), .out_ready(fetch_ready), .out_data(fetch_data)
  );

  fd_resolve_stage resolve0 (
    .clk(clk), .inf(inf),
    .in_valid(fetch_valid), .in_ready(fetch_ready), .in_data(fetch_data),
    .out_valid(resolve_valid), .out_ready(resolve_ready), .out_data(resolve_data)
  );

  fd_commit_stage commit0 (
    .clk(clk), .inf(inf),
    .in_valid(resolve_valid), .in_ready(resolve_ready), .in_data(resolve_data),
    .mem(commit_mem), .pend_release(pend_release),
    .out_valid(out_valid), .out_ready(out_ready), .out_err(out_err),
    .out_complete(out_complete), .out_info(out_info)
  );

  fd_mem_arbiter arb0 (
    .clk(clk), .inf(inf),
    .fetch_port(fetch_mem), .commit_port(commit_mem), .mem(mem_bus)
  );

endmodule

//--- testbench/fd_tb_model.svh
/*
  testbench model for the food delivery platform
  random source, record memory storage and the reference result function
*/
`ifndef FD_TB_MODEL_SVH
`define FD_TB_MODEL_SVH

typedef struct packed {
  fd_cmd_pkg::err_t err;
  logic             complete;
  logic [63:0]      info;
} expect_t;

// words seen by the DUT, and the model's copy kept in command order
fd_record_pkg::record_t mem_words [256];
fd_record_pkg::record_t shadow_mem [256];

function automatic logic [31:0] lcg_next(inout logic [31:0] state);
  state = state * 32'd1664525 + 32'd1013904223;
  return state;
endfunction

// limit 200..231, foods 0..63 each, customers sometimes empty
function automatic fd_record_pkg::record_t random_record(inout logic [31:0] state);
  fd_record_pkg::record_t rec;
  logic [31:0]            r;
  r = lcg_next(state);
  rec.res.limit  = 8'd200 + {3'b000, r[31:27]};
  rec.res.food1  = {2'b00, r[26:21]};
  rec.res.food2  = {2'b00, r[20:15]};
  rec.res.food3  = {2'b00, r[14:9]};
  r = lcg_next(state);
  rec.d_man.ctm1 = r[31:16];
  rec.d_man.ctm2 = r[15:0];
  r = lcg_next(state);
  if (r[31:30] == 2'b00) begin
    rec.d_man.ctm1 = 16'd0;
  end
  if (r[29]) begin
    rec.d_man.ctm2 = 16'd0;
  end
  return rec;
endfunction

function automatic void fill_memory(inout logic [31:0] state);
  for (int i = 0; i < 256; i++) begin
    mem_words[i]  = random_record(state);
    shadow_mem[i] = mem_words[i];
  end
endfunction

function automatic void set_record(input logic [7:0] id, input fd_record_pkg::record_t rec);
  mem_words[id]  = rec;
  shadow_mem[id] = rec;
endfunction

// expected result of one command, applied to the shadow copy
function automatic expect_t model_apply(input fd_cmd_pkg::action_t action,
                                        input logic [7:0] id, input logic [1:0] food,
                                        input logic [3:0] serv);
  fd_record_pkg::record_t rec;
  expect_t                e;
  int                     total;
  rec    = shadow_mem[id];
  e.err  = fd_cmd_pkg::No_err;
  e.info = 64'd0;
  if (action == fd_cmd_pkg::Order) begin
    total = int'(rec.res.food1) + int'(rec.res.food2) + int'(rec.res.food3) + int'(serv);
    if (total > int'(rec.res.limit)) begin
      e.err = fd_cmd_pkg::Res_busy;
    end
    else begin
      if (food == 2'd1) rec.res.food1 = rec.res.food1 + {4'd0, serv};
      if (food == 2'd2) rec.res.food2 = rec.res.food2 + {4'd0, serv};
      if (food == 2'd3) rec.res.food3 = rec.res.food3 + {4'd0, serv};
      e.info = {32'd0, rec.res};
    end
  end
  else if (rec.d_man.ctm1 == 16'd0 && rec.d_man.ctm2 == 16'd0) begin
    e.err = fd_cmd_pkg::No_customers;
  end
  else begin
    rec.d_man.ctm1 = rec.d_man.ctm2;
    rec.d_man.ctm2 = 16'd0;
    e.info = {rec.d_man, 32'd0};
  end
  e.complete     = (e.err == fd_cmd_pkg::No_err);
  shadow_mem[id] = rec;
  return e;
endfunction

`endif

//--- testbench/fd_platform_tb.sv
/*
  testbench for the food delivery platform controller
  directed and random commands against a reference model and a memory responder
*/
`timescale 1ns/1ps

module fd_platform_tb;

  localparam int NUM_DIRECTED = 5;
  localparam int NUM_RANDOM   = 300;
  localparam int CLK_PERIOD   = 100;
  // 400 cycles per command plus reset
  localparam int LIMIT_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 400 + 16;

  logic                 clk;
  logic                 inf;
  logic                 cmd_valid;
  logic                 cmd_ready;
  fd_cmd_pkg::action_t  cmd_action;
  logic [7:0]           cmd_id;
  fd_cmd_pkg::food_id_t cmd_food_id;
  logic [3:0]           cmd_servings;
  logic                 out_valid;
  logic                 out_ready;
  fd_cmd_pkg::err_t     out_err;
  logic                 out_complete;
  logic [63:0]          out_info;
  logic                 mem_req_valid;
  logic                 mem_req_ready;
  logic                 mem_write;
  logic [7:0]           mem_addr;
  logic [63:0]          mem_wdata;
  logic                 mem_rsp_valid;
  logic [63:0]          mem_rdata;

  `include "fd_tb_model.svh"

  expect_t     exp_q[$];
  string       cur_test;
  int          errors = 0;
  int          checks = 0;
  int          sent = 0;
  int          received = 0;
  int          test_err_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic [31:0] stim_seed = 32'h1ea4_36d3;
  logic [31:0] mem_seed = 32'h1ea4_36d3 ^ 32'h5a5a_0001;
  logic [31:0] out_seed = 32'h1ea4_36d3 ^ 32'h0f0f_0002;
  logic        rsp_busy = 1'b0;
  int          rsp_wait = 0;
  logic [7:0]  rsp_addr = 8'd0;

  fd_platform dut0 (
    .clk(clk), .inf(inf),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_action(cmd_action),
    .cmd_id(cmd_id), .cmd_food_id(cmd_food_id), .cmd_servings(cmd_servings),
    .out_valid(out_valid), .out_ready(out_ready), .out_err(out_err),
    .out_complete(out_complete), .out_info(out_info),
    .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_write(mem_write),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_rsp_valid(mem_rsp_valid), .mem_rdata(mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", cur_test, what, expected, actual);
    end
  endtask

  // ----------------------------------------------------------------------
  // memory responder, 1 to 6 cycles per request
  initial begin
    logic [31:0] r;
    forever begin
      @(negedge clk);
      mem_rsp_valid = 1'b0;
      if (rsp_busy) begin
        rsp_wait--;
        if (rsp_wait == 0) begin
          mem_rsp_valid = 1'b1;
          mem_rdata     = mem_words[rsp_addr];
          rsp_busy      = 1'b0;
        end
      end
      r = lcg_next(mem_seed);
      mem_req_ready = (r[31:30] != 2'b00);
      #1;
      // request taken at the coming rising edge
      if (inf && mem_req_valid && mem_req_ready) begin
        if (rsp_busy) begin
          errors++;
          $display("memory request issued while another one was still open");
        end
        rsp_busy = 1'b1;
        rsp_addr = mem_addr;
        rsp_wait = int'(r[29:27]) % 6 + 1;
        if (mem_write) begin
          mem_words[mem_addr] = mem_wdata;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // result checker with random back-pressure
  initial begin
    logic [31:0] r;
    expect_t     e;
    forever begin
      @(negedge clk);
      r = lcg_next(out_seed);
      out_ready = (r[31:30] != 2'b00);
      #1;
      if (inf && out_valid && out_ready) begin
        received++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("result arrived with no command outstanding in %s", cur_test);
        end
        else begin
          e = exp_q.pop_front();
          check_value("err", {60'd0, e.err}, {60'd0, out_err});
          check_value("complete", {63'd0, e.complete}, {63'd0, out_complete});
          check_value("info", e.info, out_info);
        end
      end
    end
  end

  task automatic send_cmd(input fd_cmd_pkg::action_t action, input logic [7:0] id,
                          input logic [1:0] food, input logic [3:0] serv);
    @(negedge clk);
    cmd_valid    = 1'b1;
    cmd_action   = action;
    cmd_id       = id;
    cmd_food_id  = food;
    cmd_servings = serv;
    #1;
    while (!cmd_ready) begin
      @(negedge clk);
      #1;
    end
    exp_q.push_back(model_apply(action, id, food, serv));
    sent++;
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic open_test(input string name);
    cur_test       = name;
    test_err_start = errors;
  endtask

  task automatic close_test();
    idle_cycle();
    wait (received == sent);
    tests_run++;
    if (errors == test_err_start) begin
      $display("test %s: passed", cur_test);
    end
    else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", cur_test, errors - test_err_start);
    end
  endtask

  initial begin
    logic [31:0]         r;
    logic [7:0]          id;
    fd_cmd_pkg::action_t act;
    inf           = 1'b0;
    cmd_valid     = 1'b0;
    cmd_action    = fd_cmd_pkg::Order;
    cmd_id        = 8'd0;
    cmd_food_id   = 2'd0;
    cmd_servings  = 4'd0;
    out_ready     = 1'b0;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rdata     = 64'd0;
    fill_memory(stim_seed);
    // directed records: d_man {ctm1, ctm2}, res {limit, food1, food2, food3}
    set_record(8'd40, {16'h0000, 16'h0000, 8'd210, 8'd20, 8'd30, 8'd40});
    set_record(8'd41, {16'h0000, 16'h0000, 8'd200, 8'd100, 8'd50, 8'd45});
    set_record(8'd42, {16'h1234, 16'h5678, 8'd200, 8'd0, 8'd0, 8'd0});
    set_record(8'd43, {16'h0000, 16'h0000, 8'd200, 8'd0, 8'd0, 8'd0});
    repeat (16) @(posedge clk);
    @(negedge clk);
    inf = 1'b1;

    open_test("order_ok");
    send_cmd(fd_cmd_pkg::Order, 8'd40, 2'd2, 4'd9);
    close_test();
    open_test("order_busy");
    send_cmd(fd_cmd_pkg::Order, 8'd41, 2'd1, 4'd10);
    send_cmd(fd_cmd_pkg::Order, 8'd41, 2'd1, 4'd5);
    close_test();
    open_test("deliver_ok");
    send_cmd(fd_cmd_pkg::Deliver, 8'd42, 2'd0, 4'd0);
    close_test();
    open_test("deliver_empty");
    send_cmd(fd_cmd_pkg::Deliver, 8'd43, 2'd0, 4'd0);
    close_test();

    // mostly ids 0..3 so the scoreboard sees repeats
    open_test("random_stream");
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r   = lcg_next(stim_seed);
      id  = (r[31:30] != 2'b00) ? {6'd0, r[29:28]} : r[27:20];
      act = r[19] ? fd_cmd_pkg::Order : fd_cmd_pkg::Deliver;
      send_cmd(act, id, r[18:17], r[16:13]);
      if (r[12:10] == 3'd0) begin
        idle_cycle();
      end
    end
    close_test();

    open_test("memory_final");
    for (int i = 0; i < 256; i++) begin
      check_value($sformatf("word %0d", i), shadow_mem[i], mem_words[i]);
    end
    close_test();

    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end
    else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- sources.f
+incdir+testbench
logic/fd_record_pkg.sv
logic/fd_cmd_pkg.sv
logic/fd_mem_if.sv
logic/fd_pipe_reg.sv
logic/fd_mem_arbiter.sv
logic/fd_fetch_stage.sv
logic/fd_resolve_stage.sv
logic/fd_commit_stage.sv
logic/fd_platform.sv
testbench/fd_platform_tb.sv

//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert
TOP        = fd_platform_tb
RTL_TOP    = fd_platform
FILELIST   = sources.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation did not finish"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
